// File: exu_settings.svh
// ------------------------------
// Widths, reset and trap vectors, target
// mask and PC step of the execution stage
// ------------------------------

`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

`define EXU_XLEN        32              // Data and PC width
`define EXU_RF_AW       5               // Register address width

`define EXU_RST_VECTOR  32'h0000_0200   // PC after reset exit
`define EXU_TRAP_VECTOR 32'h0000_0100   // Fixed trap entry, no CSR unit

`define EXU_JUMP_MASK   32'hFFFF_FFFE   // Clears target bit 0
`define EXU_PC_STEP     4               // RVI only

`endif

// File: exu_pkg.sv
// ------------------------------
// Execution stage types
// ALU commands, selectors, exception codes, command
// ------------------------------

`include "exu_settings.svh"

package exu_pkg;

// ------------------------------
// IALU commands
// ------------------------------
typedef enum logic [4:0] {
    IALU_CMD_NONE,
    IALU_CMD_ADD,
    IALU_CMD_SUB,
    IALU_CMD_AND,
    IALU_CMD_OR,
    IALU_CMD_XOR,
    IALU_CMD_SLL,
    IALU_CMD_SRL,
    IALU_CMD_SRA,
    IALU_CMD_SLT,
    IALU_CMD_SLTU,
    IALU_CMD_EQ,                    // Compare flag only from here on
    IALU_CMD_NE,
    IALU_CMD_LT,
    IALU_CMD_GE,
    IALU_CMD_LTU,
    IALU_CMD_GEU
} ialu_cmd_e;

typedef enum logic {
    IALU_OP_REG_REG,                // rs1, rs2
    IALU_OP_REG_IMM                 // rs1, imm
} ialu_op_sel_e;

typedef enum logic {
    SUM2_OP_REG_IMM,                // rs1 + imm
    SUM2_OP_PC_IMM                  // pc + imm
} sum2_op_sel_e;

typedef enum logic [2:0] {
    RD_WB_NONE   = 3'd0,
    RD_WB_IALU   = 3'd1,
    RD_WB_SUM2   = 3'd2,
    RD_WB_IMM    = 3'd3,
    RD_WB_INC_PC = 3'd4             // Link value
} rd_wb_sel_e;

typedef enum logic [3:0] {
    EXC_CODE_INSTR_MISALIGN = 4'd0,
    EXC_CODE_ILLEGAL_INSTR  = 4'd2,
    EXC_CODE_BREAKPOINT     = 4'd3,
    EXC_CODE_ECALL_M        = 4'd11
} exc_code_e;

// New PC sources
typedef enum logic [2:0] {
    PC_SRC_RST,
    PC_SRC_TRAP,
    PC_SRC_CURR,                    // WFI resume
    PC_SRC_INC,                     // FENCE.I
    PC_SRC_TARGET                   // Jump or taken branch
} pc_src_e;

// ------------------------------
// Decoded command
// ------------------------------
typedef struct packed {
    ialu_cmd_e                  ialu_cmd;
    ialu_op_sel_e               ialu_op;
    sum2_op_sel_e               sum2_op;
    rd_wb_sel_e                 rd_wb_sel;
    logic                       jump_req;
    logic                       branch_req;
    logic                       fencei_req;
    logic                       wfi_req;
    logic                       exc_req;        // Decoder detected exception
    exc_code_e                  exc_code;
    logic [`EXU_RF_AW-1:0]      rs1_addr;
    logic [`EXU_RF_AW-1:0]      rs2_addr;
    logic [`EXU_RF_AW-1:0]      rd_addr;
    logic [`EXU_XLEN-1:0]       imm;
} exu_cmd_s;

endpackage

// File: exu_issue_if.sv
// ------------------------------
// Queued command from control to datapath,
// compare flag and address sum back
// ------------------------------

`timescale 1ns/1ps
`include "exu_settings.svh"

interface exu_issue_if import exu_pkg::*; ();

logic                       cmd_vd;     // Command register valid
exu_cmd_s                   cmd;        // Command register
logic                       ialu_cmp;   // Branch condition
logic [`EXU_XLEN-1:0]       sum2_res;   // Address adder result

// Control side owns the queue
modport ctrl (
    output cmd_vd,
    output cmd,
    input  ialu_cmp,
    input  sum2_res
);

// Datapath side, the ALU drives the results and the PC unit only reads them
modport dp (
    input  cmd_vd,
    input  cmd,
    output ialu_cmp,
    output sum2_res
);

endinterface

// File: exu_control.sv
// ------------------------------
// Command queue, barrier, exceptions,
// WFI state, PC request and write-back control
// ------------------------------

`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_control import exu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_req,
    input  exu_cmd_s                cmd_in,
    output logic                    cmd_rdy,
    input  logic                    irq_pending,
    exu_issue_if.ctrl               issue,
    input  logic                    init_pc,
    input  logic [`EXU_XLEN-1:0]    curr_pc,
    output logic [`EXU_RF_AW-1:0]   rf_rs1_addr,
    output logic [`EXU_RF_AW-1:0]   rf_rs2_addr,
    output logic                    rf_w_req,
    output logic [`EXU_RF_AW-1:0]   rf_rd_addr,
    output logic                    take_exc,
    output exc_code_e               exc_code_out,
    output logic [`EXU_XLEN-1:0]    trap_val,
    output logic                    instret,
    output logic                    wfi_halted,
    output logic                    pc_update,
    output logic                    new_pc_req,
    output pc_src_e                 pc_src
);

localparam logic [`EXU_XLEN-1:0] JUMP_MASK = `EXU_JUMP_MASK;

logic                       queue_barrier;
logic                       fencei_vd;
logic                       jb_taken;
logic                       jb_misalign;
logic [`EXU_XLEN-1:0]       jb_target;
logic                       exc_req;
exc_code_e                  exc_code;
logic                       wfi_run2halt;
logic                       wfi_run_start;

// ------------------------------
// Command queue
// ------------------------------
assign queue_barrier = wfi_halted | wfi_run2halt | wfi_run_start;
assign cmd_rdy       = ~queue_barrier;

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        issue.cmd_vd <= 1'b0;
    end else if (queue_barrier) begin
        issue.cmd_vd <= 1'b0;
    end else begin
        issue.cmd_vd <= cmd_req & ~new_pc_req;      // Flushed like a fetch
    end
end

always_ff @(posedge clk) begin
    if (cmd_req & cmd_rdy) begin
        issue.cmd <= cmd_in;
    end
end

assign rf_rs1_addr = issue.cmd_vd ? issue.cmd.rs1_addr : '0;
assign rf_rs2_addr = issue.cmd_vd ? issue.cmd.rs2_addr : '0;

// ------------------------------
// Exceptions
// ------------------------------
assign jb_target   = issue.sum2_res & JUMP_MASK;
assign jb_taken    = issue.cmd_vd
                   & (issue.cmd.jump_req | (issue.cmd.branch_req & issue.ialu_cmp));
assign jb_misalign = jb_taken & jb_target[1];  // Bit 0 already masked
assign exc_req     = issue.cmd_vd & (issue.cmd.exc_req | jb_misalign);

always_comb begin
    if (issue.cmd.exc_req) begin                // Decoder has priority
        exc_code = issue.cmd.exc_code;
    end else if (jb_misalign) begin
        exc_code = EXC_CODE_INSTR_MISALIGN;
    end else begin
        exc_code = EXC_CODE_ECALL_M;
    end
end

always_comb begin
    case (exc_code)
        EXC_CODE_INSTR_MISALIGN : trap_val = jb_target;
        EXC_CODE_ILLEGAL_INSTR  : trap_val = issue.cmd.imm;
        default                 : trap_val = '0;
    endcase
end

assign take_exc     = exc_req;
assign exc_code_out = exc_code;
assign instret      = issue.cmd_vd;              // Single-cycle execution

// ------------------------------
// WFI halt and resume
// ------------------------------
assign wfi_run2halt = ~wfi_halted & issue.cmd_vd & issue.cmd.wfi_req
                    & ~issue.cmd.exc_req & ~irq_pending;

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        wfi_halted    <= 1'b0;
        wfi_run_start <= 1'b0;
    end else begin
        wfi_run_start <= wfi_halted & irq_pending;
        if (wfi_run2halt) begin
            wfi_halted <= 1'b1;
        end else if (wfi_halted & irq_pending) begin
            wfi_halted <= 1'b0;
        end
    end
end

// ------------------------------
// New PC and write-back
// ------------------------------
assign fencei_vd  = issue.cmd_vd & issue.cmd.fencei_req;
assign new_pc_req = init_pc | exc_req | fencei_vd | wfi_run_start | jb_taken;
assign pc_update  = init_pc | instret;

always_comb begin
    if (init_pc) begin
        pc_src = PC_SRC_RST;
    end else if (exc_req) begin
        pc_src = PC_SRC_TRAP;
    end else if (wfi_run_start) begin
        pc_src = PC_SRC_CURR;                   // Restart where the core halted
    end else if (fencei_vd) begin
        pc_src = PC_SRC_INC;
    end else begin
        pc_src = PC_SRC_TARGET;
    end
end

assign rf_w_req   = issue.cmd_vd & (issue.cmd.rd_wb_sel != RD_WB_NONE) & ~exc_req;
assign rf_rd_addr = issue.cmd.rd_addr;

a_jb_exclusive : assert property (
    @(posedge clk) disable iff (~rst_n)
    issue.cmd_vd |-> ~(issue.cmd.jump_req & issue.cmd.branch_req)
) else $error("EXU: jump and branch set in one command");

a_no_cmd_halted : assert property (
    @(posedge clk) disable iff (~rst_n)
    wfi_halted |-> ~issue.cmd_vd
) else $error("EXU: command queued while WFI halted");

// PC unit must hold the PC through the halt
a_pc_hold_halted : assert property (
    @(posedge clk) disable iff (~rst_n)
    wfi_halted |=> $stable(curr_pc)
) else $error("EXU: PC changed while WFI halted");

endmodule

// File: exu_ialu.sv
// ------------------------------
// Operand select, integer ALU,
// branch comparator and address adder
// ------------------------------

`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_ialu import exu_pkg::*; (
    exu_issue_if.dp                 issue,
    input  logic [`EXU_XLEN-1:0]    rs1_data,
    input  logic [`EXU_XLEN-1:0]    rs2_data,
    input  logic [`EXU_XLEN-1:0]    curr_pc,
    output logic [`EXU_XLEN-1:0]    ialu_res
);

localparam int SHAMT_W = $clog2(`EXU_XLEN);

logic [`EXU_XLEN-1:0]       op1;
logic [`EXU_XLEN-1:0]       op2;
logic [SHAMT_W-1:0]         shamt;
logic                       cmp_eq;
logic                       cmp_lt;
logic                       cmp_ltu;
logic [`EXU_XLEN-1:0]       sum2_op1;

// ------------------------------
// Operands
// ------------------------------
always_comb begin
    op1 = rs1_data;
    op2 = (issue.cmd.ialu_op == IALU_OP_REG_REG) ? rs2_data : issue.cmd.imm;
    // Keep the ALU inputs quiet between commands
    if (~issue.cmd_vd) begin
        op1 = '0;
        op2 = '0;
    end
end

assign shamt   = op2[SHAMT_W-1:0];
assign cmp_eq  = (op1 == op2);
assign cmp_ltu = (op1 < op2);
assign cmp_lt  = ($signed(op1) < $signed(op2));

// ------------------------------
// Main ALU
// ------------------------------
always_comb begin
    case (issue.cmd.ialu_cmd)
        IALU_CMD_ADD  : ialu_res = op1 + op2;
        IALU_CMD_SUB  : ialu_res = op1 - op2;
        IALU_CMD_AND  : ialu_res = op1 & op2;
        IALU_CMD_OR   : ialu_res = op1 | op2;
        IALU_CMD_XOR  : ialu_res = op1 ^ op2;
        IALU_CMD_SLL  : ialu_res = op1 << shamt;
        IALU_CMD_SRL  : ialu_res = op1 >> shamt;
        IALU_CMD_SRA  : ialu_res = $unsigned($signed(op1) >>> shamt);
        IALU_CMD_SLT  : ialu_res = `EXU_XLEN'(cmp_lt);
        IALU_CMD_SLTU : ialu_res = `EXU_XLEN'(cmp_ltu);
        default       : ialu_res = '0;          // Compares and NONE
    endcase
end

// Branch condition
always_comb begin
    case (issue.cmd.ialu_cmd)
        IALU_CMD_EQ  : issue.ialu_cmp = cmp_eq;
        IALU_CMD_NE  : issue.ialu_cmp = ~cmp_eq;
        IALU_CMD_LT  : issue.ialu_cmp = cmp_lt;
        IALU_CMD_GE  : issue.ialu_cmp = ~cmp_lt;
        IALU_CMD_LTU : issue.ialu_cmp = cmp_ltu;
        IALU_CMD_GEU : issue.ialu_cmp = ~cmp_ltu;
        default      : issue.ialu_cmp = 1'b0;
    endcase
end

// ------------------------------
// Address adder
// ------------------------------
assign sum2_op1       = (issue.cmd.sum2_op == SUM2_OP_REG_IMM) ? rs1_data : curr_pc;
assign issue.sum2_res = sum2_op1 + issue.cmd.imm;   // Target and SUM2 value

endmodule

// File: exu_pc_unit.sv
// ------------------------------
// Reset-exit sequencer, current PC,
// PC increment and new PC select
// ------------------------------

`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_pc_unit import exu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    exu_issue_if.dp                 issue,
    input  logic                    pc_update,
    input  logic                    new_pc_req,
    input  pc_src_e                 pc_src,
    output logic                    init_pc,
    output logic [`EXU_XLEN-1:0]    curr_pc,
    output logic [`EXU_XLEN-1:0]    inc_pc,
    output logic [`EXU_XLEN-1:0]    new_pc
);

localparam logic [`EXU_XLEN-1:0] RST_VECTOR  = `EXU_RST_VECTOR;
localparam logic [`EXU_XLEN-1:0] TRAP_VECTOR = `EXU_TRAP_VECTOR;
localparam logic [`EXU_XLEN-1:0] JUMP_MASK   = `EXU_JUMP_MASK;
localparam logic [`EXU_XLEN-1:0] PC_STEP     = `EXU_PC_STEP;

logic [3:0]                 init_pc_v;

// Shift in ones after reset, pulse once on the third edge
always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        init_pc_v <= '0;
    end else if (~&init_pc_v) begin
        init_pc_v <= {init_pc_v[2:0], 1'b1};
    end
end

assign init_pc = ~init_pc_v[3] & init_pc_v[2];
assign inc_pc  = curr_pc + PC_STEP;

always_comb begin
    case (pc_src)
        PC_SRC_RST  : new_pc = RST_VECTOR;
        PC_SRC_TRAP : new_pc = TRAP_VECTOR;
        PC_SRC_CURR : new_pc = curr_pc;
        PC_SRC_INC  : new_pc = inc_pc;
        default     : new_pc = issue.sum2_res & JUMP_MASK;
    endcase
end

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        curr_pc <= RST_VECTOR;
    end else if (pc_update) begin
        if (new_pc_req) begin
            curr_pc <= new_pc;
        end else begin
            curr_pc[5:0] <= inc_pc[5:0];
            // Upper bits toggle only on a carry through bit 6
            if (inc_pc[6] ^ curr_pc[6]) begin
                curr_pc[`EXU_XLEN-1:6] <= inc_pc[`EXU_XLEN-1:6];
            end
        end
    end
end

a_new_pc_aligned : assert property (
    @(posedge clk) disable iff (~rst_n)
    new_pc_req |-> ~new_pc[0]
) else $error("EXU: new PC has bit 0 set");

// Target source only for a queued jump or taken branch
a_target_src : assert property (
    @(posedge clk) disable iff (~rst_n)
    (new_pc_req && pc_src == PC_SRC_TARGET) |->
        issue.cmd_vd && (issue.cmd.jump_req || (issue.cmd.branch_req && issue.ialu_cmp))
) else $error("EXU: target PC selected without a taken jump or branch");

endmodule

// File: exu_top.sv
// ------------------------------
// Execution stage top level
// ------------------------------

`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_top import exu_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // Command
    input  logic                    cmd_req,
    output logic                    cmd_rdy,
    input  ialu_cmd_e               ialu_cmd,
    input  ialu_op_sel_e            ialu_op,
    input  sum2_op_sel_e            sum2_op,
    input  rd_wb_sel_e              rd_wb_sel,
    input  logic                    jump_req,
    input  logic                    branch_req,
    input  logic                    fencei_req,
    input  logic                    wfi_req,
    input  logic                    exc_req,
    input  exc_code_e               exc_code,
    input  logic [`EXU_RF_AW-1:0]   rs1_addr,
    input  logic [`EXU_RF_AW-1:0]   rs2_addr,
    input  logic [`EXU_RF_AW-1:0]   rd_addr,
    input  logic [`EXU_XLEN-1:0]    imm,
    // Register file
    output logic [`EXU_RF_AW-1:0]   rf_rs1_addr,
    output logic [`EXU_RF_AW-1:0]   rf_rs2_addr,
    input  logic [`EXU_XLEN-1:0]    rf_rs1_data,
    input  logic [`EXU_XLEN-1:0]    rf_rs2_data,
    output logic                    rf_w_req,
    output logic [`EXU_RF_AW-1:0]   rf_rd_addr,
    output logic [`EXU_XLEN-1:0]    rf_rd_data,
    input  logic                    irq_pending,
    // Results and status
    output logic                    take_exc,
    output exc_code_e               exc_code_out,
    output logic [`EXU_XLEN-1:0]    trap_val,
    output logic                    instret,
    output logic                    new_pc_req,
    output logic [`EXU_XLEN-1:0]    new_pc,
    output logic [`EXU_XLEN-1:0]    curr_pc,
    output logic                    wfi_halted
);

exu_cmd_s                   cmd_in;
logic                       init_pc;
logic                       pc_update;
pc_src_e                    pc_src;
logic [`EXU_XLEN-1:0]       ialu_res;
logic [`EXU_XLEN-1:0]       inc_pc;

exu_issue_if issue_bus ();

assign cmd_in = '{ialu_cmd: ialu_cmd, ialu_op: ialu_op, sum2_op: sum2_op,
                  rd_wb_sel: rd_wb_sel, jump_req: jump_req, branch_req: branch_req,
                  fencei_req: fencei_req, wfi_req: wfi_req, exc_req: exc_req,
                  exc_code: exc_code, rs1_addr: rs1_addr, rs2_addr: rs2_addr,
                  rd_addr: rd_addr, imm: imm};

// Write-back data select
always_comb begin
    case (issue_bus.cmd.rd_wb_sel)
        RD_WB_SUM2   : rf_rd_data = issue_bus.sum2_res;
        RD_WB_IMM    : rf_rd_data = issue_bus.cmd.imm;
        RD_WB_INC_PC : rf_rd_data = inc_pc;
        default      : rf_rd_data = ialu_res;
    endcase
end

exu_control u_control (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_req        (cmd_req),
    .cmd_in         (cmd_in),
    .cmd_rdy        (cmd_rdy),
    .irq_pending    (irq_pending),
    .issue          (issue_bus.ctrl),
    .init_pc        (init_pc),
    .curr_pc        (curr_pc),
    .rf_rs1_addr    (rf_rs1_addr),
    .rf_rs2_addr    (rf_rs2_addr),
    .rf_w_req       (rf_w_req),
    .rf_rd_addr     (rf_rd_addr),
    .take_exc       (take_exc),
    .exc_code_out   (exc_code_out),
    .trap_val       (trap_val),
    .instret        (instret),
    .wfi_halted     (wfi_halted),
    .pc_update      (pc_update),
    .new_pc_req     (new_pc_req),
    .pc_src         (pc_src)
);

exu_ialu u_ialu (
    .issue          (issue_bus.dp),
    .rs1_data       (rf_rs1_data),
    .rs2_data       (rf_rs2_data),
    .curr_pc        (curr_pc),
    .ialu_res       (ialu_res)
);

exu_pc_unit u_pc_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue          (issue_bus.dp),
    .pc_update      (pc_update),
    .new_pc_req     (new_pc_req),
    .pc_src         (pc_src),
    .init_pc        (init_pc),
    .curr_pc        (curr_pc),
    .inc_pc         (inc_pc),
    .new_pc         (new_pc)
);

endmodule

// File: tb_exu.sv
// ------------------------------
// Testbench for the execution stage
// Clock, register-file model, stimulus,
// reference function, checker, timeout
// ------------------------------

`timescale 1ns/1ps
`include "exu_settings.svh"

module tb_exu import exu_pkg::*; ();

localparam int N_ALU   = 300;
localparam int N_JB    = 150;
localparam int N_EXC   = 60;
localparam int N_TAIL  = 20;
localparam int N_TOTAL = N_ALU + N_JB + N_EXC + N_TAIL + 1;
localparam int LIMIT   = 2 * N_TOTAL + 200;

typedef struct {
    logic                   wb_req;
    logic [31:0]            wb_data;
    logic                   npc_req;
    logic [31:0]            npc;
    logic                   exc;
    logic [31:0]            exc_code;
    logic [31:0]            tval;
} exp_s;

logic clk = 1'b0;
logic rst_n;
logic cmd_req, cmd_rdy, irq_pending;
exu_cmd_s cmd_drv;
logic [4:0] rf_rs1_addr, rf_rs2_addr, rf_rd_addr;
logic [31:0] rf_rs1_data, rf_rs2_data, rf_rd_data, trap_val, new_pc, curr_pc;
logic rf_w_req, take_exc, instret, new_pc_req, wfi_halted;
exc_code_e exc_code_out;

logic [31:0] rf [32];
logic [31:0] seed = 32'hfa53;
logic [31:0] model_pc = `EXU_RST_VECTOR;
exu_cmd_s pending [$];
string test_name = "reset";
int errors = 0;
int checks = 0;
int retired = 0;
int cycles = 0;

always #20 clk = ~clk;

exu_top dut (
    .clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd_rdy(cmd_rdy),
    .ialu_cmd(cmd_drv.ialu_cmd), .ialu_op(cmd_drv.ialu_op), .sum2_op(cmd_drv.sum2_op),
    .rd_wb_sel(cmd_drv.rd_wb_sel), .jump_req(cmd_drv.jump_req),
    .branch_req(cmd_drv.branch_req), .fencei_req(cmd_drv.fencei_req),
    .wfi_req(cmd_drv.wfi_req), .exc_req(cmd_drv.exc_req), .exc_code(cmd_drv.exc_code),
    .rs1_addr(cmd_drv.rs1_addr), .rs2_addr(cmd_drv.rs2_addr),
    .rd_addr(cmd_drv.rd_addr), .imm(cmd_drv.imm),
    .rf_rs1_addr(rf_rs1_addr), .rf_rs2_addr(rf_rs2_addr),
    .rf_rs1_data(rf_rs1_data), .rf_rs2_data(rf_rs2_data),
    .rf_w_req(rf_w_req), .rf_rd_addr(rf_rd_addr), .rf_rd_data(rf_rd_data),
    .irq_pending(irq_pending), .take_exc(take_exc), .exc_code_out(exc_code_out),
    .trap_val(trap_val), .instret(instret), .new_pc_req(new_pc_req),
    .new_pc(new_pc), .curr_pc(curr_pc), .wfi_halted(wfi_halted)
);

// ------------------------------
// Register-file model
// ------------------------------
assign rf_rs1_data = rf[rf_rs1_addr];
assign rf_rs2_data = rf[rf_rs2_addr];

always @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < 32; i++) begin
            rf[i] <= (i == 0) ? 32'h0 : (32'(i) * 32'h9e37_79b9) ^ 32'hfa53;
        end
    end else if (rf_w_req && rf_rd_addr != 5'd0) begin
        rf[rf_rd_addr] <= rf_rd_data;   // x0 stays zero
    end
end

function logic [31:0] rand32();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

// ------------------------------
// Reference model and checks
// ------------------------------
function automatic exp_s ref_model(exu_cmd_s c, logic [31:0] rs1, logic [31:0] rs2,
                                   logic [31:0] pc);
    exp_s e;
    logic [31:0] op2, alu, target;
    logic cmp, taken, mis;
    op2 = (c.ialu_op == IALU_OP_REG_REG) ? rs2 : c.imm;
    case (c.ialu_cmd)
        IALU_CMD_ADD  : alu = rs1 + op2;
        IALU_CMD_SUB  : alu = rs1 - op2;
        IALU_CMD_AND  : alu = rs1 & op2;
        IALU_CMD_OR   : alu = rs1 | op2;
        IALU_CMD_XOR  : alu = rs1 ^ op2;
        IALU_CMD_SLL  : alu = rs1 << op2[4:0];
        IALU_CMD_SRL  : alu = rs1 >> op2[4:0];
        IALU_CMD_SRA  : alu = $unsigned($signed(rs1) >>> op2[4:0]);
        IALU_CMD_SLT  : alu = {31'b0, $signed(rs1) < $signed(op2)};
        IALU_CMD_SLTU : alu = {31'b0, rs1 < op2};
        default       : alu = 32'h0;
    endcase
    case (c.ialu_cmd)
        IALU_CMD_EQ  : cmp = (rs1 == op2);
        IALU_CMD_NE  : cmp = (rs1 != op2);
        IALU_CMD_LT  : cmp = $signed(rs1) < $signed(op2);
        IALU_CMD_GE  : cmp = $signed(rs1) >= $signed(op2);
        IALU_CMD_LTU : cmp = rs1 < op2;
        IALU_CMD_GEU : cmp = rs1 >= op2;
        default      : cmp = 1'b0;
    endcase
    target     = (((c.sum2_op == SUM2_OP_REG_IMM) ? rs1 : pc) + c.imm);
    taken      = c.jump_req | (c.branch_req & cmp);
    mis        = taken & target[1];
    e.exc      = c.exc_req | mis;
    e.exc_code = c.exc_req ? 32'(c.exc_code) : 32'd0;
    e.tval     = (e.exc_code == 32'd0) ? (target & 32'hFFFF_FFFE)
               : (e.exc_code == 32'd2) ? c.imm : 32'h0;
    e.npc_req  = e.exc | c.fencei_req | taken;
    e.npc      = e.exc ? `EXU_TRAP_VECTOR : c.fencei_req ? pc + 32'd4 : target & 32'hFFFF_FFFE;
    e.wb_req   = (c.rd_wb_sel != RD_WB_NONE) & ~e.exc;
    case (c.rd_wb_sel)
        RD_WB_SUM2   : e.wb_data = target;
        RD_WB_IMM    : e.wb_data = c.imm;
        RD_WB_INC_PC : e.wb_data = pc + 32'd4;
        default      : e.wb_data = alu;
    endcase
    return e;
endfunction

task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
        $display("[ERROR] %s %s, expected %h, actual %h", test_name, what, exp, act);
        errors++;
    end
endtask

task automatic check_true(string what, logic cond);
    checks++;
    assert (cond === 1'b1) else begin
        $display("Check failed in %s: %s", test_name, what);
        errors++;
    end
endtask

always @(negedge clk) begin : compare
    exu_cmd_s q;
    exp_s e;
    if (rst_n) begin
        if (instret) begin
            if (pending.size() == 0) begin
                check_true("a command retired that was never issued", 1'b0);
            end else begin
                q = pending.pop_front();
                e = ref_model(q, rf[q.rs1_addr], rf[q.rs2_addr], model_pc);
                check_val("curr_pc", model_pc, curr_pc);
                check_val("rf_rs1_addr", 32'(q.rs1_addr), 32'(rf_rs1_addr));
                check_val("rf_rs2_addr", 32'(q.rs2_addr), 32'(rf_rs2_addr));
                check_val("rf_w_req", 32'(e.wb_req), 32'(rf_w_req));
                if (e.wb_req) begin
                    check_val("rf_rd_addr", 32'(q.rd_addr), 32'(rf_rd_addr));
                    check_val("rf_rd_data", e.wb_data, rf_rd_data);
                end
                check_val("take_exc", 32'(e.exc), 32'(take_exc));
                if (e.exc) begin
                    check_val("exc_code_out", e.exc_code, 32'(exc_code_out));
                    check_val("trap_val", e.tval, trap_val);
                end
                check_val("new_pc_req", 32'(e.npc_req), 32'(new_pc_req));
                if (e.npc_req) begin
                    check_val("new_pc", e.npc, new_pc);
                end
                model_pc = e.npc_req ? e.npc : model_pc + 32'd4;
                retired++;
            end
        end else begin
            check_true("no write-back without a queued command", !rf_w_req);
            check_true("no exception without a queued command", !take_exc);
            if (new_pc_req) begin              // Reset exit or WFI resume
                check_val("new_pc", model_pc, new_pc);
            end
        end
    end
end

always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
        $display("Timeout: the run did not finish within %0d cycles", LIMIT);
        $display("Some tests failed");
        $finish;
    end
end

// ------------------------------
// Stimulus
// ------------------------------
task automatic send(input exu_cmd_s c);
    bit done;
    done = 1'b0;
    while (!done) begin
        @(negedge clk);
        if (cmd_rdy) begin
            cmd_drv = c;
            cmd_req = 1'b1;
            if (!new_pc_req) begin             // Otherwise flushed, try again
                pending.push_back(c);
                done = 1'b1;
            end
        end else begin
            cmd_req = 1'b0;
        end
    end
endtask

function exu_cmd_s gen_alu();
    exu_cmd_s c;
    logic [31:0] r;
    c = '0;
    r = rand32();
    c.ialu_cmd  = ialu_cmd_e'(5'(1 + r[15:8] % 10));
    c.ialu_op   = ialu_op_sel_e'(r[0]);
    c.sum2_op   = sum2_op_sel_e'(r[1]);
    c.rd_wb_sel = (r[3:2] == 2'd2) ? RD_WB_SUM2 : (r[3:2] == 2'd3) ? RD_WB_IMM : RD_WB_IALU;
    c.rs1_addr  = r[20:16];
    c.rs2_addr  = r[25:21];
    c.rd_addr   = r[30:26];
    c.imm       = rand32();
    return c;
endfunction

function exu_cmd_s gen_jb();
    exu_cmd_s c;
    logic [31:0] r;
    c = gen_alu();
    r = rand32();
    c.imm = rand32();
    c.imm[1:0] = 2'b00;
    if (r[2:0] == 3'd0) begin
        c.ialu_cmd   = IALU_CMD_NONE;
        c.rd_wb_sel  = RD_WB_NONE;
        c.fencei_req = 1'b1;
    end else if (r[3]) begin                  // JAL or JALR
        c.jump_req  = 1'b1;
        c.rd_wb_sel = RD_WB_INC_PC;
        c.sum2_op   = r[4] ? SUM2_OP_REG_IMM : SUM2_OP_PC_IMM;
    end else begin
        c.branch_req = 1'b1;
        c.ialu_cmd   = ialu_cmd_e'(5'(11 + r[15:8] % 6));
        c.ialu_op    = IALU_OP_REG_REG;
        c.sum2_op    = SUM2_OP_PC_IMM;
        c.rd_wb_sel  = RD_WB_NONE;
        c.rs2_addr   = r[5] ? c.rs1_addr : c.rs2_addr;   // Force some equal operands
    end
    return c;
endfunction

function exu_cmd_s gen_exc();
    exu_cmd_s c;
    logic [31:0] r;
    c = gen_alu();
    r = rand32();
    if (r[0]) begin
        c.exc_req  = 1'b1;
        c.exc_code = (r[2:1] == 2'd0) ? EXC_CODE_BREAKPOINT
                   : (r[2:1] == 2'd1) ? EXC_CODE_ECALL_M : EXC_CODE_ILLEGAL_INSTR;
    end else begin                            // Target with bit 1 set
        c.jump_req  = 1'b1;
        c.sum2_op   = SUM2_OP_PC_IMM;
        c.rd_wb_sel = RD_WB_INC_PC;
        c.imm       = rand32();
        c.imm[1:0]  = 2'b10;
    end
    return c;
endfunction

initial begin
    exu_cmd_s c;
    cmd_drv     = '0;
    cmd_req     = 1'b0;
    irq_pending = 1'b0;
    rst_n       = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (2) begin
        @(negedge clk);
        check_true("no new_pc_req before the reset exit", !new_pc_req);
    end
    @(negedge clk);
    check_true("new_pc_req 3 cycles after reset", new_pc_req);
    check_val("new_pc", `EXU_RST_VECTOR, new_pc);
    check_val("curr_pc", `EXU_RST_VECTOR, curr_pc);

    test_name = "alu";
    repeat (N_ALU) send(gen_alu());
    test_name = "jump_branch";
    repeat (N_JB) send(gen_jb());
    test_name = "exception";
    repeat (N_EXC) send(gen_exc());

    test_name = "wfi";
    c = '0;
    c.wfi_req = 1'b1;
    send(c);
    @(negedge clk);
    cmd_req = 1'b0;
    check_true("cmd_rdy falls while WFI is queued", !cmd_rdy);
    @(negedge clk);
    check_true("wfi_halted rises", wfi_halted);
    repeat (3) @(negedge clk);
    check_true("core stays halted with no interrupt", wfi_halted && !cmd_rdy);
    irq_pending = 1'b1;
    @(negedge clk);
    check_true("wfi_halted clears after irq_pending", !wfi_halted);
    check_true("run-start requests a new PC", new_pc_req && !cmd_rdy);
    irq_pending = 1'b0;
    @(negedge clk);
    check_true("cmd_rdy returns after run-start", cmd_rdy && !new_pc_req);
    repeat (N_TAIL) send(gen_alu());

    @(negedge clk);
    cmd_req = 1'b0;
    repeat (3) @(negedge clk);
    check_true("every issued command retired", pending.size() == 0);
    $display("Retired %0d, checks %0d, errors %0d", retired, checks, errors);
    if (errors == 0) begin
        $display("All tests passed");
    end else begin
        $display("Some tests failed");
    end
    $finish;
end

endmodule

// File: exu_top.f
+incdir+.
exu_pkg.sv
exu_issue_if.sv
exu_control.sv
exu_ialu.sv
exu_pc_unit.sv
exu_top.sv
tb_exu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execution stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f exu_top.f --top-module tb_exu \
    -Mdir obj_dir -o tb_exu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_exu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
